// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tri_mem_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
rtl/tri_mem_pkg.sv
rtl/tri_ram.sv
rtl/mesh_load_decode.sv
rtl/tri_fetch_execute.sv
rtl/tri_result_buffer.sv
rtl/tri_mem_top.sv
tests/tri_mem_tb.sv

// ==== rtl/mesh_load_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mesh_load_decode import tri_mem_pkg::*; #(
    parameter int NUM_TRIANGLE = 512,
    parameter int NUM_VERTEX   = 1024,
    localparam int IDX_AW      = $clog2(NUM_TRIANGLE),
    localparam int VTX_AW      = $clog2(NUM_VERTEX)
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              load_valid,
    output logic                   load_ready,
    input  wire load_word_t        load_data,
    input  wire logic              fetch_busy,
    output logic                   idx_we,
    output logic [IDX_AW-1:0]      idx_waddr,
    output index_rec_t             idx_wdata,
    output logic                   vtx_we,
    output logic [VTX_AW-1:0]      vtx_waddr,
    output vertex_t                vtx_wdata,
    output logic                   mesh_ready
);

    typedef enum logic [1:0] {
        PH_INDEX,
        PH_VERTEX,
        PH_DONE
    } phase_t;

    phase_t            phase;
    logic [IDX_AW-1:0] idx_cnt;
    logic [VTX_AW-1:0] vtx_cnt;
    logic              ready_en;
    logic              accept;
    logic              index_phase;
    logic              end_index;
    logic              end_vertex;

    // RAMs are single-port, so stall the stream while execute reads
    assign load_ready  = ready_en && !fetch_busy;
    assign accept      = load_valid && load_ready;

    // an index word in the done phase starts a fresh load
    assign index_phase = (phase != PH_VERTEX);
    assign end_index   = (load_data.idx.tid == '0);
    assign end_vertex  = (load_data.vtx.flag == '0);

    assign idx_we    = accept && index_phase && !end_index;
    assign idx_waddr = (phase == PH_DONE) ? '0 : idx_cnt;
    assign idx_wdata = load_data.idx;

    assign vtx_we    = accept && (phase == PH_VERTEX) && !end_vertex;
    assign vtx_waddr = vtx_cnt;
    assign vtx_wdata = load_data.vtx.vertex;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_INDEX;
            idx_cnt    <= '0;
            vtx_cnt    <= '0;
            mesh_ready <= 1'b0;
            ready_en   <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept) begin
                case (phase)
                    PH_INDEX, PH_DONE: begin
                        mesh_ready <= 1'b0;
                        if (end_index) begin
                            phase   <= PH_VERTEX;
                            vtx_cnt <= '0;
                        end else begin
                            phase   <= PH_INDEX;
                            idx_cnt <= idx_waddr + 1'b1;
                        end
                    end
                    PH_VERTEX: begin
                        if (end_vertex) begin
                            phase      <= PH_DONE;
                            mesh_ready <= 1'b1;
                        end else begin
                            vtx_cnt <= vtx_cnt + 1'b1;
                        end
                    end
                    default: phase <= PH_INDEX;
                endcase
            end
        end
    end

    // execute only reads a fully loaded mesh
    a_busy_needs_mesh: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_busy |-> mesh_ready
    );

endmodule

`default_nettype wire

// ==== rtl/tri_fetch_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_fetch_execute import tri_mem_pkg::*; #(
    parameter int NUM_TRIANGLE = 512,
    parameter int NUM_VERTEX   = 1024,
    localparam int IDX_AW      = $clog2(NUM_TRIANGLE),
    localparam int VTX_AW      = $clog2(NUM_VERTEX)
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire logic [IDX_AW-1:0] req_id,
    input  wire logic              mesh_ready,
    input  wire logic              out_busy,
    output logic                   fetch_busy,
    output logic [IDX_AW-1:0]      idx_raddr,
    input  wire index_rec_t        idx_rdata,
    output logic [VTX_AW-1:0]      vtx_raddr,
    input  wire vertex_t           vtx_rdata,
    output logic                   beat_valid,
    output beat_t                  beat,
    output logic                   release_pf,
    output logic                   drop_pf
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_IDX,
        S_V0,
        S_V1,
        S_V2
    } state_t;

    state_t            state;
    index_rec_t        rec;
    logic              is_pf;
    logic              pf_held;
    logic              have_last;
    logic [IDX_AW-1:0] pf_id;
    logic [IDX_AW-1:0] last_id;
    logic              accept;
    logic              hit;
    logic              start_fetch;
    logic              start_pf;
    logic              abort;

    assign req_ready   = mesh_ready && !out_busy && (state == S_IDLE);
    assign accept      = req_valid && req_ready;
    assign hit         = accept && pf_held && (req_id == pf_id);
    assign start_fetch = accept && !hit;
    assign start_pf    = (state == S_IDLE) && mesh_ready && have_last && !pf_held && !req_valid;

    // a waiting request for some other triangle cuts the prefetch short
    assign abort = is_pf && (state != S_IDLE) && req_valid && mesh_ready && !out_busy &&
                   (req_id != pf_id);

    assign release_pf = hit;
    assign drop_pf    = (accept && pf_held && !hit) || abort || (pf_held && !mesh_ready);
    assign fetch_busy = (state != S_IDLE) || start_fetch || start_pf;

    assign idx_raddr = start_fetch ? req_id : last_id + 1'b1;

    always_comb begin
        case (state)
            S_IDX:   vtx_raddr = idx_rdata.v0[VTX_AW-1:0];
            S_V0:    vtx_raddr = rec.v1[VTX_AW-1:0];
            default: vtx_raddr = rec.v2[VTX_AW-1:0];
        endcase
    end

    assign beat_valid    = ((state == S_V0) || (state == S_V1) || (state == S_V2)) && !abort;
    assign beat.slot     = (state == S_V0) ? 2'd0 : (state == S_V1) ? 2'd1 : 2'd2;
    assign beat.vertex   = vtx_rdata;
    assign beat.tid      = rec.tid;
    assign beat.prefetch = is_pf;

    // index record, kept for the remaining vertex reads
    always_ff @(posedge clk) begin
        if (state == S_IDX) begin
            rec <= idx_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            is_pf     <= 1'b0;
            pf_held   <= 1'b0;
            have_last <= 1'b0;
            pf_id     <= '0;
            last_id   <= '0;
        end else begin
            if (accept) begin
                last_id   <= req_id;
                have_last <= 1'b1;
            end
            if (drop_pf || hit) begin
                pf_held <= 1'b0;
            end
            if (abort) begin
                state <= S_IDLE;
                is_pf <= 1'b0;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (start_fetch) begin
                            state <= S_IDX;
                            is_pf <= 1'b0;
                        end else if (start_pf) begin
                            state <= S_IDX;
                            is_pf <= 1'b1;
                            pf_id <= last_id + 1'b1;
                        end
                    end
                    S_IDX: state <= S_V0;
                    S_V0:  state <= S_V1;
                    S_V1:  state <= S_V2;
                    default: begin
                        state <= S_IDLE;
                        if (is_pf) begin
                            pf_held <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // a demand sequence only starts into an empty result buffer
    a_demand_into_idle_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_valid && !is_pf && (state == S_V0) |-> !out_busy
    );

endmodule

`default_nettype wire

// ==== rtl/tri_mem_pkg.sv ====
`default_nettype none

package tri_mem_pkg;

    localparam int TID_W = 32;

    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
    } vertex_t;

    // one triangle in the index table
    typedef struct packed {
        logic [31:0]      v0;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [TID_W-1:0] tid;
    } index_rec_t;

    // second load phase, flag of zero ends the load
    typedef struct packed {
        vertex_t     vertex;
        logic [31:0] flag;
    } vtx_word_t;

    typedef union packed {
        index_rec_t idx;
        vtx_word_t  vtx;
    } load_word_t;

    typedef struct packed {
        vertex_t          v0;
        vertex_t          v1;
        vertex_t          v2;
        logic [TID_W-1:0] tid;
    } tri_rsp_t;

    // one vertex on its way from execute to result
    typedef struct packed {
        logic [1:0]       slot;
        vertex_t          vertex;
        logic [TID_W-1:0] tid;
        logic             prefetch;
    } beat_t;

endpackage

`default_nettype wire

// ==== rtl/tri_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_mem_top import tri_mem_pkg::*; #(
    parameter int NUM_TRIANGLE = 512,
    parameter int NUM_VERTEX   = 1024,
    localparam int IDX_AW      = $clog2(NUM_TRIANGLE),
    localparam int VTX_AW      = $clog2(NUM_VERTEX)
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              load_valid,
    output logic                   load_ready,
    input  wire load_word_t        load_data,
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire logic [IDX_AW-1:0] req_id,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output tri_rsp_t               rsp
);

    logic              idx_we;
    logic [IDX_AW-1:0] idx_waddr;
    logic [IDX_AW-1:0] idx_raddr;
    index_rec_t        idx_wdata;
    index_rec_t        idx_rdata;
    logic              vtx_we;
    logic [VTX_AW-1:0] vtx_waddr;
    logic [VTX_AW-1:0] vtx_raddr;
    vertex_t           vtx_wdata;
    vertex_t           vtx_rdata;
    logic              mesh_ready;
    logic              fetch_busy;
    logic              out_busy;
    logic              beat_valid;
    beat_t             beat;
    logic              release_pf;
    logic              drop_pf;

    mesh_load_decode #(
        .NUM_TRIANGLE (NUM_TRIANGLE),
        .NUM_VERTEX   (NUM_VERTEX)
    ) decode_i (
        .clk, .rst_n, .load_valid, .load_ready, .load_data, .fetch_busy,
        .idx_we, .idx_waddr, .idx_wdata, .vtx_we, .vtx_waddr, .vtx_wdata, .mesh_ready
    );

    tri_fetch_execute #(
        .NUM_TRIANGLE (NUM_TRIANGLE),
        .NUM_VERTEX   (NUM_VERTEX)
    ) execute_i (
        .clk, .rst_n, .req_valid, .req_ready, .req_id, .mesh_ready, .out_busy, .fetch_busy,
        .idx_raddr, .idx_rdata, .vtx_raddr, .vtx_rdata, .beat_valid, .beat,
        .release_pf, .drop_pf
    );

    tri_result_buffer result_i (
        .clk, .rst_n, .beat_valid, .beat, .release_pf, .drop_pf,
        .rsp_valid, .rsp_ready, .rsp, .out_busy
    );

    // decode and execute never drive the same RAM in one cycle
    tri_ram #(.DEPTH(NUM_TRIANGLE), .T(index_rec_t)) idx_ram (
        .clk, .we(idx_we), .addr(idx_we ? idx_waddr : idx_raddr),
        .wdata(idx_wdata), .rdata(idx_rdata)
    );

    tri_ram #(.DEPTH(NUM_VERTEX), .T(vertex_t)) vtx_ram (
        .clk, .we(vtx_we), .addr(vtx_we ? vtx_waddr : vtx_raddr),
        .wdata(vtx_wdata), .rdata(vtx_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/tri_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_ram #(
    parameter int  DEPTH = 512,
    parameter type T     = logic [31:0]
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr,
    input  wire T                         wdata,
    output T                              rdata
);

    T mem [DEPTH];

    // one-cycle read latency, write and read share the port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/tri_result_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_result_buffer import tri_mem_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  beat_valid,
    input  wire beat_t beat,
    input  wire logic  release_pf,
    input  wire logic  drop_pf,
    output logic       rsp_valid,
    input  wire logic  rsp_ready,
    output tri_rsp_t   rsp,
    output logic       out_busy
);

    tri_rsp_t pf_rsp;
    logic     pf_full;
    logic     asm_busy;
    logic     dem_beat;
    logic     pf_beat;

    // drop one vertex into its slot of a response
    function automatic tri_rsp_t place_beat(tri_rsp_t cur, beat_t b);
        tri_rsp_t nxt;
        nxt = cur;
        case (b.slot)
            2'd0: begin
                nxt.v0  = b.vertex;
                nxt.tid = b.tid;
            end
            2'd1:    nxt.v1 = b.vertex;
            default: nxt.v2 = b.vertex;
        endcase
        return nxt;
    endfunction

    assign dem_beat = beat_valid && !beat.prefetch;
    assign pf_beat  = beat_valid && beat.prefetch;
    assign out_busy = rsp_valid || asm_busy;

    // demand beats only arrive while rsp_valid is low
    always_ff @(posedge clk) begin
        if (dem_beat) begin
            rsp <= place_beat(rsp, beat);
        end else if (release_pf && pf_full) begin
            rsp <= pf_rsp;
        end
        if (pf_beat) begin
            pf_rsp <= place_beat(pf_rsp, beat);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            asm_busy  <= 1'b0;
            pf_full   <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            if ((dem_beat && beat.slot == 2'd2) || (release_pf && pf_full)) begin
                rsp_valid <= 1'b1;
            end
            if (dem_beat) begin
                asm_busy <= (beat.slot != 2'd2);
            end
            if (pf_beat && beat.slot == 2'd2) begin
                pf_full <= 1'b1;
            end
            if (release_pf || drop_pf) begin
                pf_full <= 1'b0;
            end
        end
    end

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

endmodule

`default_nettype wire

// ==== tests/tri_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_mem_tb import tri_mem_pkg::*; ();

    localparam int DUT_TRI  = 64;
    localparam int DUT_VTX  = 128;
    localparam int IDX_AW   = $clog2(DUT_TRI);
    localparam int MESH_TRI = 12;
    localparam int MESH_VTX = 20;
    localparam int TIMEOUT  = 200;
    localparam int N_TAB    = 10;
    localparam int N_RAND   = 12;

    // request table, consecutive ids first so the prefetch gets used
    int tab_id    [N_TAB] = '{0, 1, 2, 3, 4, 7, 2, 3, 11, 5};
    int tab_stall [N_TAB] = '{0, 0, 3, 0, 1, 0, 0, 5, 0, 2};

    logic              clk = 1'b0;
    logic              rst_n;
    logic              load_valid;
    logic              load_ready;
    load_word_t        load_data;
    logic              req_valid;
    logic              req_ready;
    logic [IDX_AW-1:0] req_id;
    logic              rsp_valid;
    logic              rsp_ready;
    tri_rsp_t          rsp;

    // model mesh and the load words built from it
    index_rec_t model_idx [MESH_TRI];
    vertex_t    model_vtx [MESH_VTX];
    load_word_t load_tab  [$];

    int   errors    = 0;
    int   tests     = 0;
    int   bad_tests = 0;
    logic hung      = 1'b0;

    tri_mem_top #(
        .NUM_TRIANGLE (DUT_TRI),
        .NUM_VERTEX   (DUT_VTX)
    ) tri_mem_top_i (
        .clk, .rst_n, .load_valid, .load_ready, .load_data,
        .req_valid, .req_ready, .req_id, .rsp_valid, .rsp_ready, .rsp
    );

    always #2 clk = ~clk;

    task automatic check_rsp(input string name, input tri_rsp_t got, input tri_rsp_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout: no %s within %0d cycles, stopping the run", what, TIMEOUT);
        errors++;
        hung = 1'b1;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            bad_tests++;
            $display("%s: %0d mismatches", name, errors - errs_before);
        end
    endtask

    // triangle id -> index record -> three vertices
    function automatic tri_rsp_t expected_rsp(input int id);
        tri_rsp_t   r;
        index_rec_t rec;
        rec   = model_idx[id];
        r.v0  = model_vtx[rec.v0];
        r.v1  = model_vtx[rec.v1];
        r.v2  = model_vtx[rec.v2];
        r.tid = rec.tid;
        return r;
    endfunction

    // random mesh, tids start above base so two meshes differ
    task automatic build_mesh(input int base);
        load_word_t w;
        load_tab.delete();
        for (int v = 0; v < MESH_VTX; v++) begin
            model_vtx[v] = {$urandom(), $urandom(), $urandom()};
        end
        for (int t = 0; t < MESH_TRI; t++) begin
            model_idx[t].v0  = $urandom_range(MESH_VTX - 1);
            model_idx[t].v1  = $urandom_range(MESH_VTX - 1);
            model_idx[t].v2  = $urandom_range(MESH_VTX - 1);
            model_idx[t].tid = base + t + 1;
            w.idx = model_idx[t];
            load_tab.push_back(w);
        end
        // zero tid closes the index phase
        w = '0;
        load_tab.push_back(w);
        for (int v = 0; v < MESH_VTX; v++) begin
            w.vtx.vertex = model_vtx[v];
            w.vtx.flag   = v + 1;
            load_tab.push_back(w);
        end
        // zero flag ends the load
        w = '0;
        load_tab.push_back(w);
    endtask

    task automatic load_words(input int first, input int last);
        int n;
        for (int i = first; i <= last && !hung; i++) begin
            load_valid = 1'b1;
            load_data  = load_tab[i];
            n = 0;
            // ready seen at the falling edge, word taken at the next rising edge
            while (!load_ready && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!load_ready) begin
                timed_out("load_ready");
            end
            @(negedge clk);
            load_valid = 1'b0;
        end
    endtask

    task automatic run_request(input int id, input int stall);
        tri_rsp_t exp;
        int       n;
        int       errs_before;
        if (hung) return;
        errs_before = errors;
        exp         = expected_rsp(id);
        rsp_ready   = 1'b0;
        req_valid   = 1'b1;
        req_id      = id[IDX_AW-1:0];
        n = 0;
        while (!req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            timed_out("req_ready");
        end
        @(negedge clk);
        req_valid = 1'b0;
        n = 0;
        while (!hung && !rsp_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!hung && !rsp_valid) begin
            timed_out("rsp_valid");
        end
        if (!hung) begin
            check_rsp("rsp", rsp, exp);
            // stalled response must hold still and block new requests
            for (int s = 0; s < stall; s++) begin
                @(negedge clk);
                check_flag("rsp_valid", rsp_valid, 1'b1);
                check_flag("req_ready", req_ready, 1'b0);
                check_rsp("rsp", rsp, exp);
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
            // one transfer, nothing queued behind it
            check_flag("rsp_valid", rsp_valid, 1'b0);
        end
        end_test($sformatf("request id %0d stall %0d", id, stall), errs_before);
    endtask

    task automatic run_requests();
        for (int i = 0; i < N_TAB; i++) begin
            run_request(tab_id[i], tab_stall[i]);
        end
        for (int i = 0; i < N_RAND; i++) begin
            run_request($urandom_range(MESH_TRI - 1), $urandom_range(6));
        end
    endtask

    initial begin
        int errs;
        void'($urandom(1));
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_data  = '0;
        req_valid  = 1'b0;
        req_id     = '0;
        rsp_ready  = 1'b0;

        errs = errors;
        repeat (2) begin
            @(negedge clk);
            check_flag("load_ready", load_ready, 1'b0);
            check_flag("req_ready", req_ready, 1'b0);
            check_flag("rsp_valid", rsp_valid, 1'b0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("load_ready", load_ready, 1'b1);
        check_flag("req_ready", req_ready, 1'b0);
        check_flag("rsp_valid", rsp_valid, 1'b0);
        end_test("reset", errs);

        build_mesh(100);
        errs = errors;
        load_words(0, load_tab.size() - 2);
        // end-of-vertex word still missing
        req_valid = 1'b1;
        req_id    = '0;
        repeat (12) begin
            @(negedge clk);
            check_flag("req_ready", req_ready, 1'b0);
        end
        req_valid = 1'b0;
        load_words(load_tab.size() - 1, load_tab.size() - 1);
        end_test("no requests before mesh ready", errs);

        run_requests();

        // second mesh replaces the first
        build_mesh(500);
        errs = errors;
        load_words(0, load_tab.size() - 1);
        end_test("reload mesh", errs);

        run_requests();

        $display("%0d tests, %0d failed, %0d errors", tests, bad_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
